/* cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data word and address width
`define WORD_SIZE 16

`define NUM_REGS 4
`define REG_IDX_W $clog2(`NUM_REGS)

// memory size in words
`define MEM_DEPTH 256
`define MEM_ADDR_W $clog2(`MEM_DEPTH)

`endif

/* cpuPkg.sv */
`include "cpu_macros.svh"

package cpuPkg;

    typedef enum logic [3:0] {
        OP_BNE = 4'd0, OP_BEQ = 4'd1, OP_ADI = 4'd4, OP_LHI = 4'd6, OP_LWD = 4'd7,
        OP_SWD = 4'd8, OP_JMP = 4'd9, OP_JAL = 4'd10, OP_RTYPE = 4'd15
    } opcodeT;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0, FN_SUB = 6'd1, FN_AND = 6'd2, FN_ORR = 6'd3,
        FN_JPR = 6'd25, FN_WWD = 6'd28, FN_HLT = 6'd29
    } funcT;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_PASSA} aluOpT;

    typedef struct packed {
        logic regDst;
        logic isJumpI;
        logic isJumpR;
        logic isBranch;
        logic aluSrc;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic regWrite;
        logic isWwd;
        logic isHlt;
        logic linkWrite;
    } ctrlT;

    typedef struct packed {
        logic                  valid;
        ctrlT                  ctrl;
        opcodeT                opcode;
        funcT                  func;
        logic [`WORD_SIZE-1:0] imm;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rt;
        logic [`REG_IDX_W-1:0] rd;
        // address of the next instruction, used for links and branch targets
        logic [`WORD_SIZE-1:0] pc;
        logic [`WORD_SIZE-1:0] data1;
        logic [`WORD_SIZE-1:0] data2;
    } idExT;

    typedef struct packed {
        logic                  valid;
        logic                  memRead;
        logic                  memWrite;
        logic                  memToReg;
        logic                  regWrite;
        logic                  isWwd;
        logic                  isHlt;
        logic [`WORD_SIZE-1:0] result;
        logic [`WORD_SIZE-1:0] storeData;
        logic [`REG_IDX_W-1:0] rd;
    } exMemT;

    typedef struct packed {
        logic                  valid;
        logic                  memToReg;
        logic                  regWrite;
        logic                  isWwd;
        logic                  isHlt;
        logic [`WORD_SIZE-1:0] result;
        logic [`WORD_SIZE-1:0] loadData;
        logic [`REG_IDX_W-1:0] rd;
    } memWbT;

    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [`WORD_SIZE-1:0] addr;
        logic [`WORD_SIZE-1:0] writeData;
    } memReqT;

endpackage

/* regFile.sv */
`include "cpu_macros.svh"

module regFile (
    input  logic                  Clk,
    input  logic                  arstN,
    input  logic [`REG_IDX_W-1:0] rs,
    input  logic [`REG_IDX_W-1:0] rt,
    input  logic [`REG_IDX_W-1:0] rd,
    input  logic [`WORD_SIZE-1:0] writeData,
    input  logic                  writeEn,
    output logic [`WORD_SIZE-1:0] readData1,
    output logic [`WORD_SIZE-1:0] readData2
);
    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (writeEn) begin
            regs[rd] <= writeData;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign readData1 = (writeEn && rd == rs) ? writeData : regs[rs];
    assign readData2 = (writeEn && rd == rt) ? writeData : regs[rt];

endmodule

/* alu.sv */
`include "cpu_macros.svh"

module alu (
    input  cpuPkg::opcodeT        opcode,
    input  cpuPkg::funcT          func,
    input  logic [`WORD_SIZE-1:0] a,
    input  logic [`WORD_SIZE-1:0] b,
    output logic [`WORD_SIZE-1:0] result,
    output logic                  branchTaken
);
    import cpuPkg::*;

    aluOpT op;

    always_comb begin
        case (opcode)
            OP_RTYPE: begin
                case (func)
                    FN_ADD:  op = ALU_ADD;
                    FN_SUB:  op = ALU_SUB;
                    FN_AND:  op = ALU_AND;
                    FN_ORR:  op = ALU_OR;
                    // JPR, WWD and HLT carry rs through
                    default: op = ALU_PASSA;
                endcase
            end
            OP_BNE, OP_BEQ: op = ALU_SUB;
            OP_JAL:         op = ALU_PASSA;
            // immediates and memory addresses
            default:        op = ALU_ADD;
        endcase
    end

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            default: result = a;
        endcase
        // low immediate byte goes to the upper half
        if (opcode == OP_LHI) begin
            result = b << (`WORD_SIZE / 2);
        end
    end

    // branches compare through the subtractor
    assign branchTaken = (opcode == OP_BEQ) ? (result == '0) :
                         (opcode == OP_BNE) ? (result != '0) : 1'b0;

endmodule

/* controlUnit.sv */
`include "cpu_macros.svh"

module controlUnit (
    input  logic [`WORD_SIZE-1:0] instr,
    output cpuPkg::ctrlT          ctrl
);
    import cpuPkg::*;

    opcodeT opcode;
    funcT   func;

    assign opcode = opcodeT'(instr[15:12]);
    assign func   = funcT'(instr[5:0]);

    always_comb begin
        ctrl = '0;
        case (opcode)
            OP_RTYPE: begin
                case (func)
                    FN_ADD, FN_SUB, FN_AND, FN_ORR: begin
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                    end
                    FN_JPR:  ctrl.isJumpR = 1'b1;
                    FN_WWD:  ctrl.isWwd   = 1'b1;
                    FN_HLT:  ctrl.isHlt   = 1'b1;
                    default: ;
                endcase
            end
            OP_ADI, OP_LHI: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OP_LWD: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OP_SWD: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            OP_BNE, OP_BEQ: ctrl.isBranch = 1'b1;
            OP_JMP:         ctrl.isJumpI  = 1'b1;
            OP_JAL: begin
                ctrl.isJumpI   = 1'b1;
                ctrl.linkWrite = 1'b1;
                ctrl.regWrite  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* hazardUnit.sv */
`include "cpu_macros.svh"

module hazardUnit (
    input  logic [`REG_IDX_W-1:0] idRs,
    input  logic [`REG_IDX_W-1:0] idRt,
    input  logic                  idUsesRs,
    input  logic                  idUsesRt,
    input  logic [`REG_IDX_W-1:0] exRs,
    input  logic [`REG_IDX_W-1:0] exRt,
    input  logic [`REG_IDX_W-1:0] exMemRd,
    input  logic                  exMemRegWrite,
    input  logic [`REG_IDX_W-1:0] memWbRd,
    input  logic                  memWbRegWrite,
    input  logic [`REG_IDX_W-1:0] idExRd,
    input  logic                  idExMemRead,
    output logic [1:0]            forwardA,
    output logic [1:0]            forwardB,
    output logic                  loadStall
);
    // 01 selects EX/MEM, 10 selects MEM/WB, nearer stage first
    assign forwardA = (exMemRegWrite && exMemRd == exRs) ? 2'b01 :
                      (memWbRegWrite && memWbRd == exRs) ? 2'b10 : 2'b00;
    assign forwardB = (exMemRegWrite && exMemRd == exRt) ? 2'b01 :
                      (memWbRegWrite && memWbRd == exRt) ? 2'b10 : 2'b00;

    // load data is not ready until MEM/WB, so decode waits one cycle
    assign loadStall = idExMemRead &&
                       ((idUsesRs && idRs == idExRd) || (idUsesRt && idRt == idExRd));

endmodule

/* datapath.sv */
`include "cpu_macros.svh"

module datapath (
    input  logic                  Clk,
    input  logic                  arstN,
    input  logic                  hold,
    output logic [`WORD_SIZE-1:0] pc,
    input  logic [`WORD_SIZE-1:0] instr,
    output cpuPkg::memReqT        dataReq,
    input  logic [`WORD_SIZE-1:0] readData,
    output logic [`WORD_SIZE-1:0] wwdPort,
    output logic [`WORD_SIZE-1:0] numInst,
    output logic                  wwdStrobe,
    output logic                  halted
);
    import cpuPkg::*;

    localparam logic [`REG_IDX_W-1:0] linkReg = 2;

    logic [`WORD_SIZE-1:0] ifIdInstr, ifIdPc;
    logic                  ifIdValid;
    idExT                  idEx, idNext;
    exMemT                 exMem;
    memWbT                 memWb;
    ctrlT                  idCtrl;
    logic [`REG_IDX_W-1:0] idRs, idRt;
    logic                  idUsesRs, idUsesRt, idJump;
    logic [`WORD_SIZE-1:0] idData1, idData2;
    logic [1:0]            forwardA, forwardB;
    logic                  loadStall, branchTaken, exRedirect;
    logic [`WORD_SIZE-1:0] fwdA, fwdB, aluA, aluB, aluResult, exTarget, wbData;
    logic                  advance, haltRetire;

    assign advance    = !hold && !halted;
    assign haltRetire = memWb.valid && memWb.isHlt;

    assign idRs     = ifIdInstr[11:10];
    assign idRt     = ifIdInstr[9:8];
    assign idJump   = ifIdValid && idCtrl.isJumpI;
    assign idUsesRs = ifIdValid && !idCtrl.isJumpI && idNext.opcode != OP_LHI;
    assign idUsesRt = ifIdValid && (idCtrl.isBranch || idCtrl.memWrite || idCtrl.regDst);

    controlUnit u_controlUnit (.instr(ifIdInstr), .ctrl(idCtrl));

    regFile u_regFile (
        .Clk, .arstN, .rs(idRs), .rt(idRt), .rd(memWb.rd), .writeData(wbData),
        .writeEn(memWb.valid && memWb.regWrite && !hold),
        .readData1(idData1), .readData2(idData2)
    );

    always_comb begin
        idNext.valid  = ifIdValid;
        idNext.ctrl   = ifIdValid ? idCtrl : '0;
        idNext.opcode = opcodeT'(ifIdInstr[15:12]);
        idNext.func   = funcT'(ifIdInstr[5:0]);
        idNext.imm    = {{(`WORD_SIZE - 8){ifIdInstr[7]}}, ifIdInstr[7:0]};
        idNext.rs     = idRs;
        idNext.rt     = idRt;
        // JAL always links into register 2
        idNext.rd     = idCtrl.linkWrite ? linkReg : (idCtrl.regDst ? ifIdInstr[7:6] : idRt);
        idNext.pc     = ifIdPc;
        idNext.data1  = idData1;
        idNext.data2  = idData2;
    end

    hazardUnit u_hazardUnit (
        .idRs, .idRt, .idUsesRs, .idUsesRt, .exRs(idEx.rs), .exRt(idEx.rt),
        .exMemRd(exMem.rd), .exMemRegWrite(exMem.valid && exMem.regWrite),
        .memWbRd(memWb.rd), .memWbRegWrite(memWb.valid && memWb.regWrite),
        .idExRd(idEx.rd), .idExMemRead(idEx.valid && idEx.ctrl.memRead),
        .forwardA, .forwardB, .loadStall
    );

    assign fwdA = (forwardA == 2'b01) ? exMem.result : (forwardA == 2'b10) ? wbData : idEx.data1;
    assign fwdB = (forwardB == 2'b01) ? exMem.result : (forwardB == 2'b10) ? wbData : idEx.data2;
    assign aluA = idEx.ctrl.linkWrite ? idEx.pc : fwdA;
    assign aluB = idEx.ctrl.aluSrc ? idEx.imm : fwdB;

    alu u_alu (
        .opcode(idEx.opcode), .func(idEx.func), .a(aluA), .b(aluB),
        .result(aluResult), .branchTaken
    );

    assign exRedirect = idEx.valid && (idEx.ctrl.isJumpR || (idEx.ctrl.isBranch && branchTaken));
    assign exTarget   = idEx.ctrl.isJumpR ? fwdA : idEx.pc + idEx.imm;

    // the slot behind a retiring HLT must not touch memory
    assign dataReq = '{
        read:      exMem.valid && exMem.memRead && !haltRetire,
        write:     exMem.valid && exMem.memWrite && !haltRetire,
        addr:      exMem.result,
        writeData: exMem.storeData
    };

    assign wbData = memWb.memToReg ? memWb.loadData : memWb.result;

    always_ff @(posedge Clk) begin
        if (advance && !haltRetire && !loadStall) begin
            ifIdInstr <= instr;
            ifIdPc    <= pc + 1'b1;
        end
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pc        <= '0;
            ifIdValid <= 1'b0;
            idEx      <= '0;
            exMem     <= '0;
            memWb     <= '0;
        end else if (advance) begin
            if (haltRetire) begin
                ifIdValid   <= 1'b0;
                idEx.valid  <= 1'b0;
                exMem.valid <= 1'b0;
                memWb.valid <= 1'b0;
            end else begin
                if (loadStall) begin
                    idEx <= '0;
                end else begin
                    pc <= exRedirect ? exTarget :
                          idJump ? {ifIdPc[15:12], ifIdInstr[11:0]} : pc + 1'b1;
                    ifIdValid <= !(exRedirect || idJump);
                    idEx      <= exRedirect ? '0 : idNext;
                end
                exMem.valid     <= idEx.valid;
                exMem.memRead   <= idEx.ctrl.memRead;
                exMem.memWrite  <= idEx.ctrl.memWrite;
                exMem.memToReg  <= idEx.ctrl.memToReg;
                exMem.regWrite  <= idEx.ctrl.regWrite;
                exMem.isWwd     <= idEx.ctrl.isWwd;
                exMem.isHlt     <= idEx.ctrl.isHlt;
                exMem.result    <= aluResult;
                exMem.storeData <= fwdB;
                exMem.rd        <= idEx.rd;
                memWb.valid     <= exMem.valid;
                memWb.memToReg  <= exMem.memToReg;
                memWb.regWrite  <= exMem.regWrite;
                memWb.isWwd     <= exMem.isWwd;
                memWb.isHlt     <= exMem.isHlt;
                memWb.result    <= exMem.result;
                memWb.loadData  <= readData;
                memWb.rd        <= exMem.rd;
            end
        end
    end

    // retirement
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            numInst   <= '0;
            wwdPort   <= '0;
            wwdStrobe <= 1'b0;
            halted    <= 1'b0;
        end else begin
            wwdStrobe <= 1'b0;
            if (advance && memWb.valid) begin
                numInst <= numInst + 1'b1;
                if (memWb.isWwd) begin
                    wwdPort   <= memWb.result;
                    wwdStrobe <= 1'b1;
                end
                if (memWb.isHlt) begin
                    halted <= 1'b1;
                end
            end
        end
    end

endmodule

/* unifiedMem.sv */
`include "cpu_macros.svh"

module unifiedMem (
    input  logic                  Clk,
    input  logic                  loadEn,
    input  logic [`WORD_SIZE-1:0] loadAddr,
    input  logic [`WORD_SIZE-1:0] loadData,
    input  logic [`WORD_SIZE-1:0] instrAddr,
    output logic [`WORD_SIZE-1:0] instr,
    input  cpuPkg::memReqT        dataReq,
    output logic [`WORD_SIZE-1:0] readData
);
    logic [`WORD_SIZE-1:0] mem [`MEM_DEPTH];

    // program load wins over a store from the core
    always_ff @(posedge Clk) begin
        if (loadEn) begin
            mem[loadAddr[`MEM_ADDR_W-1:0]] <= loadData;
        end else if (dataReq.write) begin
            mem[dataReq.addr[`MEM_ADDR_W-1:0]] <= dataReq.writeData;
        end
    end

    assign instr    = mem[instrAddr[`MEM_ADDR_W-1:0]];
    assign readData = dataReq.read ? mem[dataReq.addr[`MEM_ADDR_W-1:0]] : '0;

endmodule

/* cpuTop.sv */
`include "cpu_macros.svh"

module cpuTop (
    input  logic                  Clk,
    input  logic                  arstN,
    input  logic                  loadEn,
    input  logic [`WORD_SIZE-1:0] loadAddr,
    input  logic [`WORD_SIZE-1:0] loadData,
    output logic [`WORD_SIZE-1:0] wwdPort,
    output logic                  wwdStrobe,
    output logic [`WORD_SIZE-1:0] numInst,
    output logic                  halted
);
    import cpuPkg::*;

    logic [`WORD_SIZE-1:0] pc, instr, readData;
    memReqT                dataReq;

    // loading a program freezes the core
    datapath u_datapath (
        .Clk, .arstN, .hold(loadEn), .pc, .instr, .dataReq, .readData,
        .wwdPort, .numInst, .wwdStrobe, .halted
    );

    unifiedMem u_unifiedMem (
        .Clk, .loadEn, .loadAddr, .loadData, .instrAddr(pc), .instr,
        .dataReq, .readData
    );

endmodule

/* cpu_checker.sv */
`include "cpu_macros.svh"

module cpuChecker (
    input logic                  Clk,
    input logic                  arstN,
    input cpuPkg::memReqT        dataReq,
    input logic [`WORD_SIZE-1:0] pc,
    input logic                  halted
);
    // the data port serves one access per cycle
    readWriteExclusive: assert property (@(posedge Clk) disable iff (!arstN)
        !(dataReq.read && dataReq.write))
        else $error("memory read and write strobes are high together");

    // halted core neither fetches new words nor touches data memory
    quietAfterHalt: assert property (@(posedge Clk) disable iff (!arstN)
        halted |-> (!dataReq.read && !dataReq.write && $stable(pc)))
        else $error("memory access or fetch after halt");

    haltSticky: assert property (@(posedge Clk) disable iff (!arstN)
        halted |=> halted)
        else $error("halted fell without reset");

endmodule

bind cpuTop cpuChecker u_cpuChecker (.Clk, .arstN, .dataReq, .pc, .halted);

/* cpuTb.sv */
`include "cpu_macros.svh"

module cpuTb;

    logic                  Clk;
    logic                  arstN;
    logic                  loadEn;
    logic [`WORD_SIZE-1:0] loadAddr;
    logic [`WORD_SIZE-1:0] loadData;
    logic [`WORD_SIZE-1:0] wwdPort;
    logic                  wwdStrobe;
    logic [`WORD_SIZE-1:0] numInst;
    logic                  halted;

    logic [`WORD_SIZE-1:0] progAddr [$];
    logic [`WORD_SIZE-1:0] progWord [$];
    logic [`WORD_SIZE-1:0] wwdExp [$];
    logic [`WORD_SIZE-1:0] storeAddrExp [$];
    logic [`WORD_SIZE-1:0] storeDataExp [$];
    logic [`WORD_SIZE-1:0] expCount;
    int                    timeoutCycles;
    bit                    inputRead;

    cpuTop u_cpuTop (
        .Clk, .arstN, .loadEn, .loadAddr, .loadData,
        .wwdPort, .wwdStrobe, .numInst, .halted
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    task automatic stopWithFailure();
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        stopWithFailure();
    endtask

    task automatic checkValue(input string name, input logic [`WORD_SIZE-1:0] expected,
                              input logic [`WORD_SIZE-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL time %0t: %s expected %h, got %h", $time, name, expected, actual);
            stopWithFailure();
        end
    endtask

    task automatic readInputFile();
        int                    fd;
        int                    code;
        logic [7:0]            tag;
        logic [`WORD_SIZE-1:0] a;
        logic [`WORD_SIZE-1:0] b;
        logic [8*128-1:0]      line;
        fd = $fopen("cpu_input.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open cpu_input.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                break;
            end
            case (tag)
                "#": code = $fgets(line, fd);
                "P": begin
                    code = $fscanf(fd, "%h %h", a, b);
                    progAddr.push_back(a);
                    progWord.push_back(b);
                end
                "W": begin
                    code = $fscanf(fd, "%h", a);
                    wwdExp.push_back(a);
                end
                "S": begin
                    code = $fscanf(fd, "%h %h", a, b);
                    storeAddrExp.push_back(a);
                    storeDataExp.push_back(b);
                end
                "N": code = $fscanf(fd, "%h", expCount);
                default: abortRun("unknown line tag in cpu_input.txt");
            endcase
        end
        $fclose(fd);
    endtask

    // one word per cycle while the core is frozen
    task automatic loadProgram();
        foreach (progAddr[i]) begin
            @(posedge Clk);
            loadEn   <= 1'b1;
            loadAddr <= progAddr[i];
            loadData <= progWord[i];
        end
        @(posedge Clk);
        loadEn <= 1'b0;
    endtask

    always @(negedge Clk) begin
        if (arstN && wwdStrobe) begin
            if (wwdExp.size() == 0) begin
                abortRun("WWD output seen with no expected value left");
            end else begin
                checkValue("wwdPort", wwdExp[0], wwdPort);
                void'(wwdExp.pop_front());
            end
        end
    end

    always @(negedge Clk) begin
        if (arstN && u_cpuTop.dataReq.write) begin
            if (storeAddrExp.size() == 0) begin
                abortRun("data store seen with no expected store left");
            end else begin
                checkValue("dataReq.addr", storeAddrExp[0], u_cpuTop.dataReq.addr);
                checkValue("dataReq.writeData", storeDataExp[0], u_cpuTop.dataReq.writeData);
                void'(storeAddrExp.pop_front());
                void'(storeDataExp.pop_front());
            end
        end
    end

    initial begin
        wait (inputRead);
        repeat (timeoutCycles) @(posedge Clk);
        abortRun($sformatf("timeout: halted did not rise within %0d cycles", timeoutCycles));
    end

    initial begin
        inputRead  = 1'b0;
        arstN      = 1'b0;
        loadEn     = 1'b1;
        loadAddr   = '0;
        loadData   = '0;
        readInputFile();
        timeoutCycles = 40 * progWord.size() + 200;
        inputRead     = 1'b1;
        repeat (16) @(posedge Clk);
        arstN <= 1'b1;
        loadProgram();
        while (!halted) @(negedge Clk);
        // core must stay quiet once halted
        repeat (20) begin
            @(negedge Clk);
            checkValue("wwdStrobe", '0, 16'(wwdStrobe));
            checkValue("dataReq.read", '0, 16'(u_cpuTop.dataReq.read));
            checkValue("dataReq.write", '0, 16'(u_cpuTop.dataReq.write));
            checkValue("halted", 16'(1), 16'(halted));
        end
        checkValue("numInst", expCount, numInst);
        checkValue("WWD values not seen", '0, 16'(wwdExp.size()));
        checkValue("stores not seen", '0, 16'(storeAddrExp.size()));
        $display("No errors");
        $finish;
    end

endmodule

/* cpu_input.txt */
# P address word = memory load, W value = expected WWD output, S address value = expected store
# N count = retired instructions up to and including HLT, all numbers in hex
# ALU ops and immediates with back-to-back dependences
P 0000 6112
P 0001 4534
P 0002 F41C
P 0003 4205
P 0004 43FD
P 0005 FB00
P 0006 F241
P 0007 F41C
P 0008 F6C2
P 0009 FCC3
P 000A FC1C
# stores, loads and load-use stalls
P 000B 403E
P 000C 8102
P 000D 7202
P 000E FAC0
P 000F FC1C
P 0010 8303
P 0011 7103
P 0012 F41C
P 0013 7204
P 0014 F81C
# branches and jumps, wrong-path words are WWDs
P 0015 1902
P 0016 0A02
P 0017 0902
P 0018 F41C
P 0019 F81C
P 001A 1501
P 001B F41C
P 001C 901F
P 001D F41C
P 001E F81C
P 001F A024
P 0020 F81C
P 0021 F01D
P 0022 F41C
P 0023 F41C
P 0024 4111
P 0025 F41C
P 0026 F819
P 0027 F41C
P 0028 F41C
# data word for the third load
P 0044 00AB
W 1234
W FFFD
W 0007
W FFFA
W FFFA
W 00AB
W 0051
W 0020
S 0042 FFFD
S 0043 FFFA
N 0020

/* pipeCpu.f */
+incdir+.
cpuPkg.sv
regFile.sv
alu.sv
controlUnit.sv
hazardUnit.sv
datapath.sv
unifiedMem.sv
cpuTop.sv
cpu_checker.sv
cpuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= pipeCpu.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG := Errors found
PASS_MSG := No errors

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build folder and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
